// ==== common/icache_pkg.sv ====
package icache_pkg;

	// cache geometry
	localparam int ADDR_WIDTH     = 32;
	localparam int WORD_WIDTH     = 64;
	localparam int BEAT_WIDTH     = 32;
	localparam int LINE_WIDTH     = 256;
	localparam int NUM_WAYS       = 4;
	localparam int NUM_SETS       = 16;
	localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
	localparam int BEATS_PER_LINE = LINE_WIDTH / BEAT_WIDTH;

	// address fields
	localparam int LINE_OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
	localparam int WORD_OFFSET_WIDTH = $clog2(WORD_WIDTH / 8);
	localparam int WORD_SEL_WIDTH    = LINE_OFFSET_WIDTH - WORD_OFFSET_WIDTH;
	localparam int INDEX_WIDTH       = $clog2(NUM_SETS);
	localparam int TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;
	localparam int WAY_SEL_WIDTH     = $clog2(NUM_WAYS);

	localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// victim picker
	localparam int LFSR_WIDTH = 8;
	localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 8'hA5;

	typedef logic [ADDR_WIDTH-1:0]     addr_t;
	typedef logic [TAG_WIDTH-1:0]      tag_t;
	typedef logic [INDEX_WIDTH-1:0]    index_t;
	typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
	typedef logic [WORD_WIDTH-1:0]     word_t;
	typedef logic [BEAT_WIDTH-1:0]     beat_t;
	typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;
	typedef logic [NUM_WAYS-1:0]       way_mask_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		logic  read;
		logic  flush;
		addr_t address;
	} ibus_req_t;

	typedef struct packed {
		logic  stall;
		logic  valid;
		word_t rddata;
	} ibus_resp_t;

	typedef struct packed {
		logic       arvalid;
		addr_t      araddr;
		logic [7:0] arlen;
		logic [2:0] arsize;
		logic [1:0] arburst;
	} axi_ar_t;

	typedef struct packed {
		logic  rvalid;
		beat_t rdata;
		logic  rlast;
	} axi_r_t;

	function automatic index_t get_index(addr_t addr);
		return addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
	endfunction

	function automatic tag_t get_tag(addr_t addr);
		return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	endfunction

	function automatic word_sel_t get_word_sel(addr_t addr);
		return addr[WORD_OFFSET_WIDTH +: WORD_SEL_WIDTH];
	endfunction

endpackage

// ==== icache/icache_way.sv ====
`timescale 1ns/1ns

module icache_way (
	input  logic               clk,
	input  logic               rst,
	input  icache_pkg::index_t rd_index,
	input  icache_pkg::tag_t   cmp_tag,
	input  logic               we,
	input  icache_pkg::index_t wr_index,
	input  icache_pkg::tag_t   wr_tag,
	input  icache_pkg::line_t  wr_line,
	output logic               hit,
	output icache_pkg::line_t  rd_line
);
	import icache_pkg::*;

	tag_t tag_mem [NUM_SETS];
	line_t data_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;

	index_t addr;
	tag_entry_t rd_entry;

	// single port, the refill write wins the index
	assign addr = we ? wr_index : rd_index;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (we) begin
			valid_bits[wr_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wr_line;
		end
		// read-first, old contents come out on a write
		rd_entry.valid <= valid_bits[addr];
		rd_entry.tag   <= tag_mem[addr];
		rd_line        <= data_mem[addr];
	end

	assign hit = rd_entry.valid && (rd_entry.tag == cmp_tag);

	// a line is only written while stage 2 holds the address that missed
	a_no_write_on_hit: assert property (
		@(posedge clk) disable iff (rst)
		!(we && hit)
	) else $error("icache_way: write while the way reports a hit");

endmodule

// ==== icache/icache_lookup.sv ====
`timescale 1ns/1ns

module icache_lookup (
	input  logic                                       clk,
	input  logic                                       rst,
	input  icache_pkg::ibus_req_t                      ibus_req,
	output icache_pkg::ibus_resp_t                     ibus_resp,
	output icache_pkg::index_t                         rd_index,
	output icache_pkg::tag_t                           cmp_tag,
	input  icache_pkg::way_mask_t                      way_hit,
	input  icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] way_line,
	output icache_pkg::addr_t                          miss_addr,
	output logic                                       miss,
	input  logic                                       refill_busy,
	input  logic                                       refill_done
);
	import icache_pkg::*;

	logic s1_read;
	addr_t s1_addr;
	logic s2_read;
	addr_t s2_addr;

	logic flush;
	logic stall;
	logic any_hit;
	word_t hit_word;

	logic valid_q;
	word_t rddata_q;

	assign flush   = ibus_req.flush;
	assign any_hit = |way_hit;

	// hold the pipe on a miss and for the re-read after a refill
	assign stall = refill_done | (s2_read & ~flush & ~any_hit);
	assign miss  = s2_read & ~flush & ~any_hit & ~refill_busy;

	assign miss_addr = s2_addr;
	assign cmp_tag   = get_tag(s2_addr);

	// stalled: keep reading the stage 2 set
	assign rd_index = stall ? get_index(s2_addr) : get_index(s1_addr);

	always_comb begin
		hit_word = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_word |= {WORD_WIDTH{way_hit[w]}} & way_line[w][get_word_sel(s2_addr)];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_read <= 1'b0;
			s2_read <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			// flush empties both stages and drops the incoming request
			if (flush) begin
				s1_read <= 1'b0;
				s2_read <= 1'b0;
			end else if (!stall) begin
				s1_read <= ibus_req.read;
				s2_read <= s1_read;
			end
			valid_q <= s2_read & ~stall & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if (ibus_req.read) begin
				s1_addr <= ibus_req.address;
			end
			s2_addr <= s1_addr;
		end
		rddata_q <= hit_word;
	end

	assign ibus_resp = '{stall: stall, valid: valid_q, rddata: rddata_q};

	// a set never holds the same tag in two ways
	a_hit_onehot: assert property (
		@(posedge clk) disable iff (rst)
		s2_read |-> $onehot0(way_hit)
	) else $error("icache_lookup: more than one way hit");

endmodule

// ==== icache/icache_refill.sv ====
`timescale 1ns/1ns

module icache_refill (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  miss,
	input  icache_pkg::addr_t     miss_addr,
	input  logic                  flush,
	output icache_pkg::axi_ar_t   axi_ar,
	input  logic                  arready,
	input  icache_pkg::axi_r_t    axi_r,
	output logic                  rready,
	output icache_pkg::way_mask_t way_we,
	output icache_pkg::index_t    wr_index,
	output icache_pkg::tag_t      wr_tag,
	output icache_pkg::line_t     wr_line,
	output logic                  refill_busy,
	output logic                  refill_done
);
	import icache_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_AR,
		RECEIVE,
		DRAIN,
		DONE
	} state_t;

	state_t state;
	state_t state_next;

	addr_t req_addr;
	logic flushed;
	logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
	beat_t [BEATS_PER_LINE-2:0] line_buf;

	logic [LFSR_WIDTH-1:0] lfsr;
	logic [WAY_SEL_WIDTH-1:0] victim;

	logic beat_fire;
	logic last_beat;
	logic line_write;

	assign rready     = (state == RECEIVE) || (state == DRAIN);
	assign beat_fire  = axi_r.rvalid & rready;
	assign last_beat  = beat_fire & axi_r.rlast;
	assign line_write = (state == RECEIVE) & last_beat & ~flush;

	always_comb begin
		state_next = state;
		unique case (state)
			IDLE: begin
				if (miss)
					state_next = WAIT_AR;
			end
			WAIT_AR: begin
				// the address phase completes even when flushed
				if (arready)
					state_next = (flushed | flush) ? DRAIN : RECEIVE;
			end
			RECEIVE: begin
				if (last_beat)
					state_next = flush ? IDLE : DONE;
				else if (flush)
					state_next = DRAIN;
			end
			DRAIN: begin
				if (last_beat)
					state_next = IDLE;
			end
			DONE: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			flushed  <= 1'b0;
			beat_cnt <= '0;
			lfsr     <= LFSR_SEED;
		end else begin
			state <= state_next;
			if (state == IDLE)
				flushed <= 1'b0;
			else if (state == WAIT_AR && flush)
				flushed <= 1'b1;
			if (state == WAIT_AR)
				beat_cnt <= '0;
			else if (beat_fire)
				beat_cnt <= beat_cnt + 1'b1;
			// x^8 + x^6 + x^5 + x^4 + 1
			if (line_write)
				lfsr <= {lfsr[LFSR_WIDTH-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && miss)
			req_addr <= miss_addr;
		// beats shift down, beat 0 ends at the bottom
		if (state == RECEIVE && beat_fire)
			line_buf <= {axi_r.rdata, line_buf[BEATS_PER_LINE-2:1]};
	end

	always_comb begin
		axi_ar.arvalid = (state == WAIT_AR);
		axi_ar.araddr  = {req_addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};
		axi_ar.arlen   = 8'(BEATS_PER_LINE - 1);
		axi_ar.arsize  = AXI_SIZE_4B;
		axi_ar.arburst = AXI_BURST_INCR;
	end

	// last beat goes straight into the line, no extra cycle
	assign victim   = lfsr[WAY_SEL_WIDTH-1:0];
	assign way_we   = line_write ? (way_mask_t'(1) << victim) : '0;
	assign wr_index = get_index(req_addr);
	assign wr_tag   = get_tag(req_addr);
	assign wr_line  = line_t'({axi_r.rdata, line_buf});

	assign refill_busy = (state != IDLE);
	assign refill_done = (state == DONE);

	a_rlast_on_eighth: assert property (
		@(posedge clk) disable iff (rst)
		beat_fire |-> (axi_r.rlast == (&beat_cnt))
	) else $error("icache_refill: rlast not on the eighth beat");

	a_ar_stable: assert property (
		@(posedge clk) disable iff (rst)
		axi_ar.arvalid && !arready |=> axi_ar.arvalid && $stable(axi_ar.araddr)
	) else $error("icache_refill: AR request changed before arready");

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ns

module icache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  icache_pkg::ibus_req_t  ibus_req,
	output icache_pkg::ibus_resp_t ibus_resp,
	output icache_pkg::axi_ar_t    axi_ar,
	input  logic                   arready,
	output logic                   rready,
	input  icache_pkg::axi_r_t     axi_r
);
	import icache_pkg::*;

	index_t rd_index;
	tag_t cmp_tag;
	way_mask_t way_hit;
	line_t [NUM_WAYS-1:0] way_line;

	addr_t miss_addr;
	logic miss;
	logic refill_busy;
	logic refill_done;

	way_mask_t way_we;
	index_t wr_index;
	tag_t wr_tag;
	line_t wr_line;

	icache_lookup u_lookup (
		.clk         (clk),
		.rst         (rst),
		.ibus_req    (ibus_req),
		.ibus_resp   (ibus_resp),
		.rd_index    (rd_index),
		.cmp_tag     (cmp_tag),
		.way_hit     (way_hit),
		.way_line    (way_line),
		.miss_addr   (miss_addr),
		.miss        (miss),
		.refill_busy (refill_busy),
		.refill_done (refill_done)
	);

	icache_refill u_refill (
		.clk         (clk),
		.rst         (rst),
		.miss        (miss),
		.miss_addr   (miss_addr),
		.flush       (ibus_req.flush),
		.axi_ar      (axi_ar),
		.arready     (arready),
		.axi_r       (axi_r),
		.rready      (rready),
		.way_we      (way_we),
		.wr_index    (wr_index),
		.wr_tag      (wr_tag),
		.wr_line     (wr_line),
		.refill_busy (refill_busy),
		.refill_done (refill_done)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_ways
		icache_way u_way (
			.clk      (clk),
			.rst      (rst),
			.rd_index (rd_index),
			.cmp_tag  (cmp_tag),
			.we       (way_we[w]),
			.wr_index (wr_index),
			.wr_tag   (wr_tag),
			.wr_line  (wr_line),
			.hit      (way_hit[w]),
			.rd_line  (way_line[w])
		);
	end

endmodule

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model (
	input  logic                clk,
	input  logic                rst,
	input  icache_pkg::axi_ar_t axi_ar,
	output logic                arready,
	output icache_pkg::axi_r_t  axi_r,
	input  logic                rready
);
	import icache_pkg::*;

	localparam logic [31:0] RNG_SEED = 32'h0d02_1b16;

	logic [31:0] rng;
	logic active;
	logic beat_taken;
	addr_t burst_addr;
	logic [2:0] beat;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		rng = RNG_SEED;
		arready = 1'b0;
		axi_r = '0;
	end

	// handshakes are taken on the rising edge
	always @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			beat_taken <= 1'b0;
			beat <= '0;
		end else begin
			beat_taken <= 1'b0;
			if (!active && axi_ar.arvalid && arready) begin
				active <= 1'b1;
				burst_addr <= axi_ar.araddr;
				beat <= '0;
			end else if (active && axi_r.rvalid && rready) begin
				beat_taken <= 1'b1;
				beat <= beat + 1'b1;
				if (beat == 3'd7)
					active <= 1'b0;
			end
		end
	end

	// outputs move on the falling edge, with random gaps
	always @(negedge clk) begin
		rng = xorshift32(rng);
		if (rst) begin
			arready <= 1'b0;
			axi_r <= '0;
		end else begin
			arready <= !active && rng[0];
			// an offered beat stays until it is taken
			axi_r.rvalid <= active && ((axi_r.rvalid && !beat_taken) || rng[2:1] != 2'b00);
			// beat b of line L reads L + 4*b
			axi_r.rdata <= burst_addr + {beat, 2'b00};
			axi_r.rlast <= (beat == 3'd7);
		end
	end

endmodule

// ==== testbench/tb_icache_top.sv ====
`timescale 1ns/1ns

module tb_icache_top;
	import icache_pkg::*;

	localparam logic [31:0] RNG_SEED = 32'h0d02_1b16;
	localparam int TIMEOUT = 1000;

	logic clk;
	logic rst;
	ibus_req_t ibus_req;
	ibus_resp_t ibus_resp;
	axi_ar_t axi_ar;
	logic arready;
	logic rready;
	axi_r_t axi_r;

	logic [31:0] rng;
	logic started;
	logic last_fire;
	addr_t expected_q [$];
	addr_t exp_addr;
	int errors;
	int words_checked;
	int ar_count;
	int ar_before;

	icache_top u_icache_top (
		.clk       (clk),
		.rst       (rst),
		.ibus_req  (ibus_req),
		.ibus_resp (ibus_resp),
		.axi_ar    (axi_ar),
		.arready   (arready),
		.rready    (rready),
		.axi_r     (axi_r)
	);

	axi_mem_model u_axi_mem_model (
		.clk     (clk),
		.rst     (rst),
		.axi_ar  (axi_ar),
		.arready (arready),
		.axi_r   (axi_r),
		.rready  (rready)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// beats 2w and 2w+1 of the line with the lower beat in the low half
	function automatic word_t expected_word(input addr_t a);
		logic [31:0] lo;
		lo = {a[31:5], 5'b0} + {a[4:3], 3'b000};
		return {lo + 32'd4, lo};
	endfunction

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		errors++;
		$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic flag_error(input string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("%0d words checked, %0d AR bursts, %0d errors", words_checked, ar_count, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	task automatic abort_run(input string msg);
		flag_error(msg);
		finish_run();
	endtask

	// scoreboard of accepted fetches
	always @(posedge clk) begin
		if (rst) begin
			expected_q.delete();
			last_fire = 1'b0;
		end else begin
			if (ibus_resp.valid) begin
				if (expected_q.size() == 0) begin
					flag_error("valid without an outstanding fetch");
				end else begin
					exp_addr = expected_q.pop_front();
					words_checked++;
					a_rddata: assert (ibus_resp.rddata == expected_word(exp_addr))
						else value_error("ibus_resp.rddata", ibus_resp.rddata, expected_word(exp_addr));
				end
			end
			// flush drops both stages and the fetch presented with it
			if (ibus_req.flush)
				expected_q.delete();
			last_fire = ibus_req.read && !ibus_resp.stall;
			if (last_fire && !ibus_req.flush)
				expected_q.push_back(ibus_req.address);
			if (axi_ar.arvalid && arready)
				ar_count++;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
		!started |-> !ibus_resp.stall && !ibus_resp.valid && !axi_ar.arvalid && !rready)
		else flag_error("cache active before the first fetch");

	a_hit_latency: assert property (@(posedge clk) disable iff (rst)
		(ibus_req.read && !ibus_resp.stall && !ibus_req.flush)
		##1 (!ibus_resp.stall && !ibus_req.flush) ##1 (!ibus_resp.stall && !ibus_req.flush)
		|=> ibus_resp.valid)
		else flag_error("hit gave no valid two cycles after acceptance");

	a_ar_aligned: assert property (@(posedge clk) disable iff (rst)
		axi_ar.arvalid |-> axi_ar.araddr[4:0] == 5'd0)
		else value_error("axi_ar.araddr[4:0]", $sampled(axi_ar.araddr[4:0]), 0);

	a_ar_len: assert property (@(posedge clk) disable iff (rst)
		axi_ar.arvalid |-> axi_ar.arlen == 8'd7)
		else value_error("axi_ar.arlen", $sampled(axi_ar.arlen), 7);

	a_ar_size: assert property (@(posedge clk) disable iff (rst)
		axi_ar.arvalid |-> axi_ar.arsize == 3'b010)
		else value_error("axi_ar.arsize", $sampled(axi_ar.arsize), 3'b010);

	a_ar_burst: assert property (@(posedge clk) disable iff (rst)
		axi_ar.arvalid |-> axi_ar.arburst == 2'b01)
		else value_error("axi_ar.arburst", $sampled(axi_ar.arburst), 2'b01);

	a_ar_stable: assert property (@(posedge clk) disable iff (rst)
		axi_ar.arvalid && !arready |=> axi_ar.arvalid && $stable(axi_ar.araddr))
		else flag_error("AR request changed before arready");

	task automatic fetch(input addr_t addr);
		int cycles;
		started = 1'b1;
		ibus_req.read = 1'b1;
		ibus_req.address = addr;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!last_fire && cycles < TIMEOUT);
		if (!last_fire)
			abort_run("fetch was never accepted");
	endtask

	task automatic drain_pipe();
		int cycles;
		ibus_req.read = 1'b0;
		cycles = 0;
		while ((expected_q.size() != 0 || rready || axi_ar.arvalid) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (expected_q.size() != 0 || rready || axi_ar.arvalid)
			abort_run("pipeline did not drain");
	endtask

	// flush in WAIT_AR or in RECEIVE and expect a fresh AR afterwards
	task automatic flush_miss(input addr_t addr, input logic in_receive);
		int cycles;
		fetch(addr);
		ibus_req.read = 1'b0;
		cycles = 0;
		while (!(in_receive ? rready : axi_ar.arvalid) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!(in_receive ? rready : axi_ar.arvalid))
			abort_run("refill did not start");
		ibus_req.flush = 1'b1;
		@(negedge clk);
		ibus_req.flush = 1'b0;
		drain_pipe();
		ar_before = ar_count;
		fetch(addr);
		drain_pipe();
		a_fresh_ar: assert (ar_count == ar_before + 1)
			else value_error("ar_count", ar_count - ar_before, 1);
	endtask

	initial begin
		int sel;
		clk = 1'b0;
		rst = 1'b1;
		ibus_req = '0;
		started = 1'b0;
		last_fire = 1'b0;
		rng = RNG_SEED;
		errors = 0;
		words_checked = 0;
		ar_count = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);

		// three lines cold and the same words again as back-to-back hits
		for (int i = 0; i < 12; i++)
			fetch(32'h0000_4000 + i * 8);
		drain_pipe();
		ar_before = ar_count;
		for (int i = 0; i < 12; i++)
			fetch(32'h0000_4000 + i * 8);
		drain_pipe();
		a_resident: assert (ar_count == ar_before)
			else value_error("ar_count", ar_count, ar_before);

		flush_miss(32'h0000_8008, 1'b0);
		flush_miss(32'h0000_8110, 1'b1);

		// six lines that all map to set 5
		ar_before = ar_count;
		for (int i = 0; i < 120; i++) begin
			rng = xorshift32(rng);
			sel = rng[10:8] % 6;
			fetch(32'h0001_00a0 + sel * 32'h200 + {rng[4:3], 3'b000});
			if (rng[15:13] == 3'd0) begin
				ibus_req.read = 1'b0;
				@(negedge clk);
			end
		end
		drain_pipe();
		a_refetch: assert (ar_count - ar_before > 6)
			else value_error("ar_count", ar_count - ar_before, 7);

		finish_run();
	end

endmodule

// ==== icache_top.f ====
common/icache_pkg.sv
icache/icache_way.sv
icache/icache_lookup.sv
icache/icache_refill.sv
hdl/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache_top.sv

// ==== Bender.yml ====
package:
  name: icache_top

sources:
  - common/icache_pkg.sv
  - icache/icache_way.sv
  - icache/icache_lookup.sv
  - icache/icache_refill.sv
  - hdl/icache_top.sv
  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/tb_icache_top.sv
